// ==== hw/rvv_mulmac_pkg.sv ====
// MUL/MAC cluster package with element constants, op encoding and micro-op types
package rvv_mulmac_pkg;

  // Element geometry, two 32-bit lanes per operand
  localparam int ELEM_W   = 32;
  localparam int NUM_ELEM = 2;
  localparam int VLEN_W   = ELEM_W * NUM_ELEM;

  // Reorder buffer tag width, 16 outstanding entries
  localparam int ROB_IDX_W = 4;

  // Per-element operation
  typedef enum logic [1:0] {
    // vd = low(vs1 * vs2)
    op_mul   = 2'b00,
    // vd = high(vs1 * vs2), signed
    op_mulh  = 2'b01,
    // vd = vd_old + low(vs1 * vs2)
    op_macc  = 2'b10,
    // vd = vd_old - low(vs1 * vs2)
    op_nmsac = 2'b11
  } mac_op_e;

  // Micro-op as held in the reservation station
  typedef struct packed {
    mac_op_e                op;
    logic [ROB_IDX_W-1:0]   rob_idx;
    logic [VLEN_W-1:0]      vs1;
    logic [VLEN_W-1:0]      vs2;
    // Old destination, addend for the accumulate forms
    logic [VLEN_W-1:0]      vd_old;
  } mul_uop_t;

  // Result write towards the reorder buffer
  typedef struct packed {
    logic [ROB_IDX_W-1:0]   rob_idx;
    logic [VLEN_W-1:0]      data;
  } rob_wr_t;

endpackage

// ==== hw/rvv_mul_rs_fifo.sv ====
// MUL reservation station FIFO, single push, two oldest entries visible, two-wide pop
`timescale 1ns/1ps

module rvv_mul_rs_fifo #(
  parameter int RS_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,
  input  logic                           push,
  input  rvv_mulmac_pkg::mul_uop_t       push_uop,
  input  logic [1:0]                     pop,
  output rvv_mulmac_pkg::mul_uop_t [1:0] head_uop,
  output logic                           empty,
  output logic                           one_left,
  output logic                           full
);

  localparam int PTR_W = $clog2(RS_DEPTH);

  // Entry storage, payload only
  rvv_mulmac_pkg::mul_uop_t mem [RS_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_nxt;
  // One bit wider so full and empty differ
  logic [PTR_W:0]   count;
  logic [PTR_W:0]   pop_cnt;
  logic             push_ok;

  // Push dropped when full or flushing
  assign push_ok = push && !full && !flush;

  // Zero, one or two entries leave per cycle
  assign pop_cnt = (PTR_W+1)'(pop[0]) + (PTR_W+1)'(pop[1]);

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_uop;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // Trap flush drops every queued entry
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Depth is a power of two, pointers wrap on their own
      rd_ptr <= rd_ptr + pop_cnt[PTR_W-1:0];
      count  <= count + (PTR_W+1)'(push_ok) - pop_cnt;
    end
  end

  // Second oldest entry sits one slot behind the head
  assign rd_ptr_nxt  = rd_ptr + 1'b1;
  assign head_uop[0] = mem[rd_ptr];
  assign head_uop[1] = mem[rd_ptr_nxt];

  // Level flags from the count
  assign empty    = (count == '0);
  assign one_left = (count == (PTR_W+1)'(1));
  assign full     = (count == (PTR_W+1)'(RS_DEPTH));

endmodule

// ==== hw/rvv_backend_mac_unit.sv ====
// Single MAC lane computing packed 32-bit multiply and multiply-accumulate results
`timescale 1ns/1ps

module rvv_backend_mac_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     issue,
  input  rvv_mulmac_pkg::mul_uop_t uop,
  input  logic                     res_ready,
  output logic                     uop_ready,
  output logic                     res_valid,
  output rvv_mulmac_pkg::rob_wr_t  res
);

  localparam int ELEM_W   = rvv_mulmac_pkg::ELEM_W;
  localparam int NUM_ELEM = rvv_mulmac_pkg::NUM_ELEM;

  logic [rvv_mulmac_pkg::VLEN_W-1:0] res_data;
  rvv_mulmac_pkg::rob_wr_t           res_q;
  logic                              res_vld_q;
  logic                              res_take;

  // One element of the result
  function automatic logic [ELEM_W-1:0] elem_calc(
    input rvv_mulmac_pkg::mac_op_e   op,
    input logic signed [ELEM_W-1:0]  a,
    input logic signed [ELEM_W-1:0]  b,
    input logic signed [ELEM_W-1:0]  d
  );
    logic signed [2*ELEM_W-1:0] prod;
    logic [ELEM_W-1:0]          lo;
    // Full signed product, operands sign extended
    prod = a * b;
    lo   = prod[ELEM_W-1:0];
    unique case (op)
      rvv_mulmac_pkg::op_mul:   return lo;
      rvv_mulmac_pkg::op_mulh:  return prod[2*ELEM_W-1:ELEM_W];
      // Accumulate forms wrap modulo 2^32
      rvv_mulmac_pkg::op_macc:  return d + lo;
      rvv_mulmac_pkg::op_nmsac: return d - lo;
    endcase
  endfunction

  // Same datapath for every element slice
  for (genvar e = 0; e < NUM_ELEM; e++) begin : g_elem
    assign res_data[e*ELEM_W +: ELEM_W] = elem_calc(
      uop.op,
      uop.vs1[e*ELEM_W +: ELEM_W],
      uop.vs2[e*ELEM_W +: ELEM_W],
      uop.vd_old[e*ELEM_W +: ELEM_W]
    );
  end

  // Arbiter took the held result
  assign res_take = res_valid && res_ready;

  // Free slot, or slot drains this cycle
  assign uop_ready = !res_vld_q || res_ready;

  // Result payload, loaded on issue only
  always_ff @(posedge clk) begin
    if (issue) begin
      res_q.rob_idx <= uop.rob_idx;
      res_q.data    <= res_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_vld_q <= 1'b0;
    end else if (flush) begin
      res_vld_q <= 1'b0;
    end else if (issue) begin
      res_vld_q <= 1'b1;
    end else if (res_take) begin
      res_vld_q <= 1'b0;
    end
  end

  // Hidden during the flush cycle
  assign res_valid = res_vld_q && !flush;
  assign res       = res_q;

endmodule

// ==== hw/rvv_backend_mulmac.sv ====
// MUL/MAC execution wrapper issuing two FIFO heads in order to two MAC lanes
`timescale 1ns/1ps

module rvv_backend_mulmac (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           trap_flush,
  input  rvv_mulmac_pkg::mul_uop_t [1:0] head_uop,
  input  logic                           rs_empty,
  input  logic                           rs_one_left,
  input  logic [1:0]                     res_ready,
  output logic [1:0]                     rs_pop,
  output logic [1:0]                     res_valid,
  output rvv_mulmac_pkg::rob_wr_t [1:0]  res
);

  logic [1:0] lane_valid;
  logic [1:0] mac_ready;

  // FIFO level decode
  // empty=0 one_left=0 : two or more entries
  // empty=0 one_left=1 : exactly one
  // empty=1            : nothing to issue
  assign lane_valid[0] = !rs_empty && !trap_flush;
  assign lane_valid[1] = !rs_empty && !rs_one_left && !trap_flush;

  // Lane 1 only pops together with lane 0, FIFO order kept
  assign rs_pop[0] = lane_valid[0] && mac_ready[0];
  assign rs_pop[1] = lane_valid[1] && mac_ready[1] && rs_pop[0];

  // Oldest entry to MAC 0
  rvv_backend_mac_unit mac0_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (trap_flush),
    .issue     (rs_pop[0]),
    .uop       (head_uop[0]),
    .res_ready (res_ready[0]),
    .uop_ready (mac_ready[0]),
    .res_valid (res_valid[0]),
    .res       (res[0])
  );

  // Second oldest entry to MAC 1
  rvv_backend_mac_unit mac1_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (trap_flush),
    .issue     (rs_pop[1]),
    .uop       (head_uop[1]),
    .res_ready (res_ready[1]),
    .uop_ready (mac_ready[1]),
    .res_valid (res_valid[1]),
    .res       (res[1])
  );

endmodule

// ==== hw/rvv_rob_wr_arb.sv ====
// Round-robin merge of two MAC result lanes into one reorder buffer write port
`timescale 1ns/1ps

module rvv_rob_wr_arb (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [1:0]                    res_valid,
  input  rvv_mulmac_pkg::rob_wr_t [1:0] res,
  input  logic                          rob_ready,
  output logic [1:0]                    res_ready,
  output logic                          rob_valid,
  output rvv_mulmac_pkg::rob_wr_t       rob_wr
);

  // Lane with priority when both request
  logic rr_ptr;
  logic grant_idx;
  logic xfer;

  // Single requester wins outright, otherwise the pointer decides
  always_comb begin
    if (res_valid == 2'b11) begin
      grant_idx = rr_ptr;
    end else begin
      grant_idx = res_valid[1];
    end
  end

  assign rob_valid = |res_valid;
  assign rob_wr    = res[grant_idx];
  assign xfer      = rob_valid && rob_ready;

  // Ready back to the granted lane only
  assign res_ready[0] = xfer && !grant_idx;
  assign res_ready[1] = xfer && grant_idx;

  // Loser of this transfer gets priority next, lane 0 first out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= 1'b0;
    end else if (xfer) begin
      rr_ptr <= !grant_idx;
    end
  end

endmodule

// ==== hw/rvv_mulmac_top.sv ====
// Vector MUL/MAC cluster with reservation station, two MAC lanes and ROB write arbiter
`timescale 1ns/1ps

module rvv_mulmac_top #(
  parameter int RS_DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     trap_flush,
  input  logic                     uop_push,
  input  rvv_mulmac_pkg::mul_uop_t uop_in,
  input  logic                     rob_ready,
  output logic                     rs_full,
  output logic                     rob_valid,
  output rvv_mulmac_pkg::rob_wr_t  rob_wr
);

  // FIFO heads and levels towards the issue logic
  rvv_mulmac_pkg::mul_uop_t [1:0] head_uop;
  logic                           rs_empty;
  logic                           rs_one_left;
  logic [1:0]                     rs_pop;

  // Result lanes towards the arbiter
  logic [1:0]                     res_valid;
  logic [1:0]                     res_ready;
  rvv_mulmac_pkg::rob_wr_t [1:0]  res;

  rvv_mul_rs_fifo #(
    .RS_DEPTH (RS_DEPTH)
  ) rs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (trap_flush),
    .push     (uop_push),
    .push_uop (uop_in),
    .pop      (rs_pop),
    .head_uop (head_uop),
    .empty    (rs_empty),
    .one_left (rs_one_left),
    .full     (rs_full)
  );

  rvv_backend_mulmac ex_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .trap_flush  (trap_flush),
    .head_uop    (head_uop),
    .rs_empty    (rs_empty),
    .rs_one_left (rs_one_left),
    .res_ready   (res_ready),
    .rs_pop      (rs_pop),
    .res_valid   (res_valid),
    .res         (res)
  );

  rvv_rob_wr_arb arb_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res       (res),
    .rob_ready (rob_ready),
    .res_ready (res_ready),
    .rob_valid (rob_valid),
    .rob_wr    (rob_wr)
  );

endmodule

// ==== tb/rvv_mulmac_tb.sv ====
// Testbench for the vector MUL/MAC cluster with an index-keyed scoreboard and checkers
`timescale 1ns/1ps

module rvv_mulmac_tb;

  localparam int RS_DEPTH   = 8;
  // Pushes over all tests, sizes the watchdog
  localparam int TOTAL_PUSH = 91;
  // Under full stall only MAC 0 holds a result, lane 1 never pops without lane 0
  localparam int FILL_LIMIT = RS_DEPTH + 1;

  logic                     clk;
  logic                     rst_n;
  logic                     trap_flush;
  logic                     uop_push;
  rvv_mulmac_pkg::mul_uop_t uop_in;
  logic                     rob_ready;
  logic                     rs_full;
  logic                     rob_valid;
  rvv_mulmac_pkg::rob_wr_t  rob_wr;

  // Scoreboard by ROB index
  logic [63:0] exp_data [16];
  bit          pending  [16];
  logic [3:0]  next_idx;

  // Checker state, written by the main process only
  bit                      reset_window;
  bit                      fill_mode;
  bit                      quiet;
  bit                      hold_q;
  rvv_mulmac_pkg::rob_wr_t hold_wr;
  bit                      rand_ready;
  int                      fill_cnt;
  int                      fail_cnt;
  int                      test_fails;
  int                      tests_passed;
  int                      tests_failed;
  integer                  seed;

  rvv_mulmac_top #(
    .RS_DEPTH (RS_DEPTH)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .trap_flush (trap_flush),
    .uop_push   (uop_push),
    .uop_in     (uop_in),
    .rob_ready  (rob_ready),
    .rs_full    (rs_full),
    .rob_valid  (rob_valid),
    .rob_wr     (rob_wr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Quiet outputs through reset and the first cycle after it
  a_reset: assert property (@(posedge clk) reset_window |-> (!rob_valid && !rs_full))
    else begin
      fail_cnt++;
      $display("Fail rob_valid %h rs_full %h, expected 0 0", $sampled(rob_valid),
               $sampled(rs_full));
    end

  // Transfer data against the model
  a_data: assert property (@(posedge clk) disable iff (!rst_n)
    (rob_valid && rob_ready && pending[rob_wr.rob_idx])
      |-> (rob_wr.data == exp_data[rob_wr.rob_idx]))
    else begin
      fail_cnt++;
      $display("Fail rob_wr.data idx %h expected %h actual %h", $sampled(rob_wr.rob_idx),
               exp_data[$sampled(rob_wr.rob_idx)], $sampled(rob_wr.data));
    end

  // Duplicates and stale indices land here
  a_known: assert property (@(posedge clk) disable iff (!rst_n)
    (rob_valid && rob_ready) |-> pending[rob_wr.rob_idx])
    else begin
      fail_cnt++;
      $display("Index %h transferred but was not outstanding", $sampled(rob_wr.rob_idx));
    end

  // Stalled result holds
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    hold_q |-> (trap_flush || (rob_valid && rob_wr == hold_wr)))
    else begin
      fail_cnt++;
      $display("Fail rob_wr held %h now %h", hold_wr, $sampled(rob_wr));
    end

  a_fill: assert property (@(posedge clk) disable iff (!rst_n)
    fill_mode |-> (rs_full == (fill_cnt >= FILL_LIMIT)))
    else begin
      fail_cnt++;
      $display("Fail rs_full expected %h actual %h", fill_cnt >= FILL_LIMIT, $sampled(rs_full));
    end

  // Nothing leaves after a flush until fresh work arrives
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (trap_flush || quiet) |-> !rob_valid)
    else begin
      fail_cnt++;
      $display("A result came out after the flush before any new push");
    end

  // Reference element math, signed 64-bit product
  function automatic logic [63:0] model_result(input rvv_mulmac_pkg::mac_op_e op,
                                               input logic [63:0] a, b, d);
    logic [63:0] r;
    longint      p;
    int          e;
    for (e = 0; e < 2; e++) begin
      p = longint'($signed(a[e*32 +: 32])) * longint'($signed(b[e*32 +: 32]));
      case (op)
        rvv_mulmac_pkg::op_mul:  r[e*32 +: 32] = p[31:0];
        rvv_mulmac_pkg::op_mulh: r[e*32 +: 32] = p[63:32];
        rvv_mulmac_pkg::op_macc: r[e*32 +: 32] = d[e*32 +: 32] + p[31:0];
        default:                 r[e*32 +: 32] = d[e*32 +: 32] - p[31:0];
      endcase
    end
    return r;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < 16; i++) begin
      n += int'(pending[i]);
    end
    return n;
  endfunction

  // One clock; outputs seen mid-cycle, bookkeeping after the edge
  task automatic step();
    bit                      took;
    bit                      held;
    logic [3:0]              idx;
    rvv_mulmac_pkg::rob_wr_t wr;
    int                      r;
    @(negedge clk);
    took = rst_n && rob_valid && rob_ready;
    held = rst_n && rob_valid && !rob_ready;
    idx  = rob_wr.rob_idx;
    wr   = rob_wr;
    @(posedge clk);
    #1;
    if (took) begin
      pending[idx] = 1'b0;
    end
    hold_q  = held;
    hold_wr = wr;
    if (rand_ready) begin
      r = $random(seed);
      rob_ready = r[0];
    end
  endtask

  task automatic push_op(input rvv_mulmac_pkg::mac_op_e op, input logic [63:0] a, b, d);
    // Wait for room and a free index
    while (rs_full || pending[next_idx]) begin
      uop_push = 1'b0;
      step();
    end
    uop_in.op      = op;
    uop_in.rob_idx = next_idx;
    uop_in.vs1     = a;
    uop_in.vs2     = b;
    uop_in.vd_old  = d;
    exp_data[next_idx] = model_result(op, a, b, d);
    pending[next_idx]  = 1'b1;
    quiet    = 1'b0;
    uop_push = 1'b1;
    next_idx = next_idx + 4'd1;
    step();
    uop_push = 1'b0;
    fill_cnt++;
  endtask

  task automatic push_random();
    int r;
    r = $random(seed);
    push_op(rvv_mulmac_pkg::mac_op_e'(r[1:0]), {$random(seed), $random(seed)},
            {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
  endtask

  task automatic drain(input string name);
    int n;
    n = 0;
    while (outstanding() != 0 && n < 400) begin
      step();
      n++;
    end
    a_drained: assert (outstanding() == 0)
      else begin
        fail_cnt++;
        $display("%0d results of test %s never retired", outstanding(), name);
      end
  endtask

  task automatic end_test(input string name);
    if (fail_cnt == test_fails) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: fail, %0d checks failed", name, fail_cnt - test_fails);
    end
    test_fails = fail_cnt;
  endtask

  initial begin
    seed       = 11;
    rst_n      = 1'b0;
    trap_flush = 1'b0;
    uop_push   = 1'b0;
    uop_in     = '0;
    rob_ready  = 1'b0;
    next_idx   = '0;
    reset_window = 1'b1;
    for (int i = 0; i < 16; i++) begin
      pending[i]  = 1'b0;
      exp_data[i] = '0;
    end
    repeat (4) step();
    rst_n = 1'b1;
    step();
    reset_window = 1'b0;
    end_test("reset");

    // Sign extremes on both halves
    rob_ready = 1'b1;
    push_op(rvv_mulmac_pkg::op_mul, 64'h7fffffff80000000, 64'h7fffffff80000000, 64'h0);
    push_op(rvv_mulmac_pkg::op_mulh, 64'h7fffffff80000000, 64'h7fffffff80000000, 64'h0);
    push_op(rvv_mulmac_pkg::op_mulh, 64'hffffffff80000000, 64'h000000017fffffff, 64'h0);
    push_op(rvv_mulmac_pkg::op_mul, 64'hffffffff00000000, 64'hffffffff12345678, 64'h0);
    // Accumulate forms that wrap
    push_op(rvv_mulmac_pkg::op_macc, 64'h0000000180000000, 64'h0000000100000002,
            64'hffffffff00000001);
    push_op(rvv_mulmac_pkg::op_macc, 64'h7fffffff7fffffff, 64'h7fffffff00000002,
            64'h7fffffff80000000);
    push_op(rvv_mulmac_pkg::op_nmsac, 64'h0000000180000000, 64'h0000000100000002, 64'h0);
    push_op(rvv_mulmac_pkg::op_nmsac, 64'hffffffff7fffffff, 64'hffffffff7fffffff,
            64'h8000000000000001);
    repeat (24) push_random();
    drain("ops");
    end_test("ops");

    // Half the cycles stalled
    rand_ready = 1'b1;
    repeat (40) push_random();
    drain("retire");
    rand_ready = 1'b0;
    rob_ready  = 1'b1;
    end_test("retire");

    // Full stall, FIFO and MAC 0 fill up
    rob_ready = 1'b0;
    fill_cnt  = 0;
    fill_mode = 1'b1;
    repeat (FILL_LIMIT) push_random();
    repeat (3) step();
    fill_mode = 1'b0;
    rob_ready = 1'b1;
    drain("fill");
    end_test("fill");

    // Load MAC 0, then one open cycle moves the next two heads into both lanes
    rob_ready = 1'b0;
    repeat (3) push_random();
    step();
    rob_ready = 1'b1;
    step();
    rob_ready = 1'b0;
    repeat (3) push_random();
    trap_flush = 1'b1;
    quiet      = 1'b1;
    step();
    trap_flush = 1'b0;
    // Everything in flight is gone
    for (int i = 0; i < 16; i++) begin
      pending[i] = 1'b0;
    end
    rob_ready = 1'b1;
    repeat (4) step();
    repeat (4) push_random();
    drain("flush");
    end_test("flush");

    $display("Tests passed %0d, failed %0d, failed checks %0d", tests_passed, tests_failed,
             fail_cnt);
    if (fail_cnt == 0 && tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Twenty cycles per push plus slack
  initial begin
    repeat (TOTAL_PUSH * 20 + 200) @(posedge clk);
    $display("Watchdog expired, the run stopped making progress");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
hw/rvv_mulmac_pkg.sv
hw/rvv_mul_rs_fifo.sv
hw/rvv_backend_mac_unit.sv
hw/rvv_backend_mulmac.sv
hw/rvv_rob_wr_arb.sv
hw/rvv_mulmac_top.sv
tb/rvv_mulmac_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f files.f \
		--top-module rvv_mulmac_tb -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
